// File: hdl/cpu_pkg.sv
package cpu_pkg;

	localparam int XLEN = 32;
	localparam int REG_ADDR_W = 5;

	////////////////////////////////////////
	// instruction set encodings
	////////////////////////////////////////

	// opcodes 20 to 31 are free and decode as no-ops
	typedef enum logic [4:0] {
		OP_ADD  = 5'd0,
		OP_ADDI = 5'd1,
		OP_SUB  = 5'd2,
		OP_AND  = 5'd3,
		OP_ANDI = 5'd4,
		OP_OR   = 5'd5,
		OP_ORI  = 5'd6,
		OP_XOR  = 5'd7,
		OP_SLL  = 5'd8,
		OP_SRL  = 5'd9,
		OP_SRA  = 5'd10,
		OP_LLI  = 5'd11,
		OP_LUI  = 5'd12,
		OP_LW   = 5'd13,
		OP_SW   = 5'd14,
		OP_LWO  = 5'd15,
		OP_SWO  = 5'd16,
		OP_B    = 5'd17,
		OP_BL   = 5'd18,
		OP_RET  = 5'd19
	} opcode_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA
	} alu_op_e;

	typedef enum logic [2:0] {
		COND_NE,
		COND_EQ,
		COND_GT,
		COND_LT,
		COND_GE,
		COND_LE,
		COND_OVERFLOW,
		COND_ALWAYS
	} branch_cond_e;

	typedef struct packed {
		opcode_e                 opcode;
		logic [REG_ADDR_W-1:0]   dest;
		logic [REG_ADDR_W-1:0]   src1;
		logic [REG_ADDR_W-1:0]   src2;
		logic [11:0]             unused;
	} instr_reg_t;

	typedef struct packed {
		opcode_e                 opcode;
		logic [REG_ADDR_W-1:0]   dest;
		logic [REG_ADDR_W-1:0]   src1;
		logic                    pad;
		logic [15:0]             imm16;
	} instr_imm_t;

	typedef struct packed {
		opcode_e                 opcode;
		branch_cond_e            cond;
		logic [7:0]              unused;
		logic [15:0]             imm16;
	} instr_br_t;

	// one instruction word, three ways to read it
	typedef union packed {
		instr_reg_t r;
		instr_imm_t i;
		instr_br_t  b;
	} instr_t;

	////////////////////////////////////////
	// pipeline registers
	////////////////////////////////////////

	typedef struct packed {
		logic zero;
		logic sign;
		logic overflow;
	} flags_t;

	typedef struct packed {
		alu_op_e                 alu_op;
		logic                    use_immediate;
		logic                    select_immediate;
		logic                    update_flags;
		logic [REG_ADDR_W-1:0]   src1;
		logic [REG_ADDR_W-1:0]   src2;
	} ex_ctrl_t;

	typedef struct packed {
		logic                    read;
		logic                    write;
		logic [REG_ADDR_W-1:0]   src;
	} mem_ctrl_t;

	typedef struct packed {
		logic [REG_ADDR_W-1:0]   dest;
		logic                    write;
		logic                    write_lower;
		logic                    write_upper;
	} wb_ctrl_t;

	typedef struct packed {
		logic                    valid;
		logic [XLEN-1:0]         op1;
		logic [XLEN-1:0]         op2;
		logic [XLEN-1:0]         immediate;
		ex_ctrl_t                ex;
		mem_ctrl_t               mem;
		wb_ctrl_t                wb;
	} idex_t;

	typedef struct packed {
		logic                    valid;
		logic [XLEN-1:0]         result;
		logic [XLEN-1:0]         store_data;
		mem_ctrl_t               mem;
		wb_ctrl_t                wb;
	} exmem_t;

	typedef struct packed {
		logic                    valid;
		logic [XLEN-1:0]         result;
		wb_ctrl_t                wb;
	} memwb_t;

	// write-back port, also seen outside the core
	typedef struct packed {
		logic                    valid;
		logic                    lower;
		logic                    upper;
		logic [REG_ADDR_W-1:0]   dest;
		logic [XLEN-1:0]         data;
	} rf_write_t;

endpackage

// File: hdl/register_file.sv
`timescale 1ns/1ps

module register_file import cpu_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [REG_ADDR_W-1:0] raddr1,
	input  logic [REG_ADDR_W-1:0] raddr2,
	output logic [XLEN-1:0]       rdata1,
	output logic [XLEN-1:0]       rdata2,
	input  rf_write_t             wr
);

	logic [XLEN-1:0] regs [2**REG_ADDR_W];

	// register 0 is never written
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 2**REG_ADDR_W; i++) begin
				regs[i] <= '0;
			end
		end else if (wr.valid && wr.dest != '0) begin
			if (wr.lower) begin
				regs[wr.dest][15:0] <= wr.data[15:0];
			end else if (wr.upper) begin
				regs[wr.dest][XLEN-1:16] <= wr.data[15:0];
			end else begin
				regs[wr.dest] <= wr.data;
			end
		end
	end

	// write-through, merges the halves on a half write
	function automatic logic [XLEN-1:0] read_port(
		input logic [REG_ADDR_W-1:0] addr,
		input logic [XLEN-1:0]       stored,
		input rf_write_t             w
	);
		logic [XLEN-1:0] value;
		value = stored;
		if (w.valid && w.dest == addr && addr != '0) begin
			if (w.lower) begin
				value = {stored[XLEN-1:16], w.data[15:0]};
			end else if (w.upper) begin
				value = {w.data[15:0], stored[15:0]};
			end else begin
				value = w.data;
			end
		end
		return value;
	endfunction

	assign rdata1 = read_port(raddr1, regs[raddr1], wr);
	assign rdata2 = read_port(raddr2, regs[raddr2], wr);

endmodule

// File: hdl/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage import cpu_pkg::*; #(
	parameter int IMEM_ADDR_W = 11
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   stall,
	input  logic                   branch,
	input  logic [IMEM_ADDR_W-1:0] branch_target,
	input  logic                   link,
	input  logic [IMEM_ADDR_W-1:0] link_address,
	input  logic                   ret,
	input  instr_t                 imem_data,
	output logic [IMEM_ADDR_W-1:0] imem_addr,
	output instr_t                 ifid_instr,
	output logic [IMEM_ADDR_W-1:0] ifid_pc,
	output logic                   ifid_valid
);

	logic                   pc_reset;
	logic [IMEM_ADDR_W-1:0] pc_ghost;
	logic [IMEM_ADDR_W-1:0] link_reg;

	// pc_reset keeps address 0 on the bus for the first cycle
	// pc_ghost is the address the instruction memory latched
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc_reset <= 1'b1;
			pc_ghost <= '0;
			link_reg <= '0;
		end else begin
			pc_reset <= 1'b0;
			pc_ghost <= imem_addr;
			if (link) begin
				link_reg <= link_address;
			end
		end
	end

	always_comb begin
		if (pc_reset) begin
			imem_addr = '0;
		end else if (branch) begin
			imem_addr = branch_target;
		end else if (ret) begin
			imem_addr = link_reg;
		end else if (!stall) begin
			// word addressed
			imem_addr = pc_ghost + IMEM_ADDR_W'(1);
		end else begin
			imem_addr = pc_ghost;
		end
	end

	// IF/ID
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ifid_instr <= '0;
			ifid_pc    <= '0;
			ifid_valid <= 1'b0;
		end else if (pc_reset || branch || ret) begin
			// fall-through word is dropped
			ifid_instr <= '0;
			ifid_pc    <= pc_ghost;
			ifid_valid <= 1'b0;
		end else if (!stall) begin
			ifid_instr <= imem_data;
			ifid_pc    <= pc_ghost;
			ifid_valid <= imem_data != '0;
		end
	end

endmodule

// File: hdl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import cpu_pkg::*; #(
	parameter int IMEM_ADDR_W = 11
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  instr_t                 ifid_instr,
	input  logic [IMEM_ADDR_W-1:0] ifid_pc,
	input  logic                   ifid_valid,
	input  logic                   stall,
	input  flags_t                 flags,
	input  logic [XLEN-1:0]        rf_rdata1,
	input  logic [XLEN-1:0]        rf_rdata2,
	output logic [REG_ADDR_W-1:0]  rf_raddr1,
	output logic [REG_ADDR_W-1:0]  rf_raddr2,
	output logic                   branch,
	output logic [IMEM_ADDR_W-1:0] branch_target,
	output logic                   link,
	output logic [IMEM_ADDR_W-1:0] link_address,
	output logic                   ret,
	output idex_t                  idex,
	output logic                   id_branch_pending,
	output wb_ctrl_t               id_wb
);

	ex_ctrl_t        ex_ctrl;
	mem_ctrl_t       mem_ctrl;
	logic            use_dest;
	logic            is_branch;
	logic            is_link;
	logic            is_ret;
	logic            taken;
	logic [XLEN-1:0] immediate;

	////////////////////////////////////////
	// opcode decode
	////////////////////////////////////////

	always_comb begin
		use_dest  = 1'b0;
		is_branch = 1'b0;
		is_link   = 1'b0;
		is_ret    = 1'b0;
		ex_ctrl   = '0;
		mem_ctrl  = '0;
		id_wb     = '0;
		id_wb.dest = ifid_instr.r.dest;

		case (ifid_instr.r.opcode)
			OP_SUB: ex_ctrl.alu_op = ALU_SUB;
			OP_AND, OP_ANDI: ex_ctrl.alu_op = ALU_AND;
			OP_OR, OP_ORI: ex_ctrl.alu_op = ALU_OR;
			OP_XOR: ex_ctrl.alu_op = ALU_XOR;
			OP_SLL: ex_ctrl.alu_op = ALU_SLL;
			OP_SRL: ex_ctrl.alu_op = ALU_SRL;
			OP_SRA: ex_ctrl.alu_op = ALU_SRA;
			// offset addressing adds too
			default: ex_ctrl.alu_op = ALU_ADD;
		endcase

		case (ifid_instr.r.opcode)
			OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL, OP_SRA: begin
				ex_ctrl.update_flags = 1'b1;
				id_wb.write = 1'b1;
			end
			OP_ADDI, OP_ANDI, OP_ORI: begin
				ex_ctrl.use_immediate = 1'b1;
				ex_ctrl.update_flags = 1'b1;
				id_wb.write = 1'b1;
			end
			OP_LLI: begin
				ex_ctrl.select_immediate = 1'b1;
				id_wb.write_lower = 1'b1;
			end
			OP_LUI: begin
				ex_ctrl.select_immediate = 1'b1;
				id_wb.write_upper = 1'b1;
			end
			OP_LW, OP_LWO: begin
				ex_ctrl.select_immediate = ifid_instr.r.opcode == OP_LW;
				ex_ctrl.use_immediate = ifid_instr.r.opcode == OP_LWO;
				mem_ctrl.read = 1'b1;
				id_wb.write = 1'b1;
			end
			OP_SW, OP_SWO: begin
				// store data register sits in the dest field
				use_dest = 1'b1;
				ex_ctrl.select_immediate = ifid_instr.r.opcode == OP_SW;
				ex_ctrl.use_immediate = ifid_instr.r.opcode == OP_SWO;
				mem_ctrl.write = 1'b1;
			end
			OP_B: is_branch = 1'b1;
			OP_BL: begin
				is_branch = 1'b1;
				is_link = 1'b1;
			end
			OP_RET: is_ret = 1'b1;
			default: begin
			end
		endcase

		ex_ctrl.src1 = ifid_instr.r.src1;
		ex_ctrl.src2 = use_dest ? ifid_instr.r.dest : ifid_instr.r.src2;
		mem_ctrl.src = ex_ctrl.src2;
	end

	assign rf_raddr1 = ex_ctrl.src1;
	assign rf_raddr2 = ex_ctrl.src2;

	////////////////////////////////////////
	// branches
	////////////////////////////////////////

	always_comb begin
		case (ifid_instr.b.cond)
			COND_NE: taken = !flags.zero;
			COND_EQ: taken = flags.zero;
			COND_GT: taken = !flags.zero && !flags.sign;
			COND_LT: taken = !flags.zero && flags.sign;
			COND_GE: taken = flags.zero || !flags.sign;
			COND_LE: taken = flags.zero || flags.sign;
			COND_OVERFLOW: taken = flags.overflow;
			default: taken = 1'b1;
		endcase
	end

	assign immediate = {{(XLEN-16){ifid_instr.i.imm16[15]}}, ifid_instr.i.imm16};

	assign link_address  = ifid_pc + IMEM_ADDR_W'(1);
	assign branch_target = link_address + immediate[IMEM_ADDR_W-1:0];

	// a stalled instruction is redone next cycle
	assign branch = ifid_valid && is_branch && taken && !stall;
	assign link   = ifid_valid && is_link && taken && !stall;
	assign ret    = ifid_valid && is_ret && !stall;

	assign id_branch_pending = ifid_valid && is_branch;

	// ID/EX
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			idex <= '0;
		end else if (stall || !ifid_valid) begin
			idex <= '0;
		end else begin
			idex.valid     <= 1'b1;
			idex.op1       <= rf_rdata1;
			idex.op2       <= rf_rdata2;
			idex.immediate <= immediate;
			idex.ex        <= ex_ctrl;
			idex.mem       <= mem_ctrl;
			idex.wb        <= id_wb;
		end
	end

endmodule

// File: hdl/execute_stage.sv
`timescale 1ns/1ps

module execute_stage import cpu_pkg::*; (
	input  logic            clk,
	input  logic            rst_n,
	input  idex_t           idex,
	input  logic            fwd_exmem_op1,
	input  logic            fwd_exmem_op2,
	input  logic            fwd_memwb_op1,
	input  logic            fwd_memwb_op2,
	input  logic [XLEN-1:0] memwb_result,
	output flags_t          flags,
	output exmem_t          exmem
);

	logic [XLEN-1:0] op1;
	logic [XLEN-1:0] op2;
	logic [XLEN-1:0] alu_b;
	logic [XLEN-1:0] alu_result;
	logic [XLEN-1:0] ex_result;
	flags_t          alu_flags;

	// newest value wins
	assign op1 = fwd_exmem_op1 ? exmem.result :
		fwd_memwb_op1 ? memwb_result :
		idex.op1;
	assign op2 = fwd_exmem_op2 ? exmem.result :
		fwd_memwb_op2 ? memwb_result :
		idex.op2;

	assign alu_b = idex.ex.use_immediate ? idex.immediate : op2;

	////////////////////////////////////////
	// ALU
	////////////////////////////////////////

	always_comb begin
		alu_flags.overflow = 1'b0;
		case (idex.ex.alu_op)
			ALU_ADD: begin
				alu_result = op1 + alu_b;
				alu_flags.overflow = (op1[XLEN-1] == alu_b[XLEN-1]) &&
					(alu_result[XLEN-1] != op1[XLEN-1]);
			end
			ALU_SUB: begin
				alu_result = op1 - alu_b;
				alu_flags.overflow = (op1[XLEN-1] != alu_b[XLEN-1]) &&
					(alu_result[XLEN-1] != op1[XLEN-1]);
			end
			ALU_AND: alu_result = op1 & alu_b;
			ALU_OR: alu_result = op1 | alu_b;
			ALU_XOR: alu_result = op1 ^ alu_b;
			ALU_SLL: alu_result = op1 << alu_b[4:0];
			ALU_SRL: alu_result = op1 >> alu_b[4:0];
			ALU_SRA: alu_result = $signed(op1) >>> alu_b[4:0];
			default: alu_result = '0;
		endcase
		alu_flags.zero = alu_result == '0;
		alu_flags.sign = alu_result[XLEN-1];
	end

	// lli, lui and lw pass the immediate straight through
	assign ex_result = idex.ex.select_immediate ? idex.immediate : alu_result;

	// status register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			flags <= '0;
		end else if (idex.valid && idex.ex.update_flags) begin
			flags <= alu_flags;
		end
	end

	// EX/MEM
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			exmem <= '0;
		end else begin
			exmem.valid      <= idex.valid;
			exmem.result     <= ex_result;
			exmem.store_data <= op2;
			exmem.mem        <= idex.mem;
			exmem.wb         <= idex.wb;
		end
	end

endmodule

// File: hdl/memory_stage.sv
`timescale 1ns/1ps

module memory_stage import cpu_pkg::*; #(
	parameter int DMEM_ADDR_W = 8
) (
	input  logic            clk,
	input  logic            rst_n,
	input  exmem_t          exmem,
	input  logic            fwd_store,
	input  logic [XLEN-1:0] memwb_result,
	output memwb_t          memwb
);

	logic [XLEN-1:0]        dmem [2**DMEM_ADDR_W];
	logic [DMEM_ADDR_W-1:0] addr;
	logic [XLEN-1:0]        store_data;
	logic [XLEN-1:0]        mem_result;

	// word addressed, upper address bits ignored
	assign addr = exmem.result[DMEM_ADDR_W-1:0];

	assign store_data = fwd_store ? memwb_result : exmem.store_data;

	always_ff @(posedge clk) begin
		if (exmem.valid && exmem.mem.write) begin
			dmem[addr] <= store_data;
		end
	end

	assign mem_result = exmem.mem.read ? dmem[addr] : exmem.result;

	// MEM/WB
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			memwb <= '0;
		end else begin
			memwb.valid  <= exmem.valid;
			memwb.result <= mem_result;
			memwb.wb     <= exmem.wb;
		end
	end

endmodule

// File: hdl/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit import cpu_pkg::*; (
	input  idex_t                 idex,
	input  exmem_t                exmem,
	input  memwb_t                memwb,
	input  logic [REG_ADDR_W-1:0] id_raddr1,
	input  logic [REG_ADDR_W-1:0] id_raddr2,
	input  logic                  id_branch_pending,
	input  logic                  ifid_valid,
	output logic                  fwd_exmem_op1,
	output logic                  fwd_exmem_op2,
	output logic                  fwd_memwb_op1,
	output logic                  fwd_memwb_op2,
	output logic                  fwd_store,
	output logic                  stall
);

	logic exmem_fwd_ok;
	logic memwb_fwd_ok;
	logic load_use;
	logic branch_flags;
	logic half_read;

	function automatic logic id_reads(
		input logic [REG_ADDR_W-1:0] dest,
		input logic [REG_ADDR_W-1:0] a1,
		input logic [REG_ADDR_W-1:0] a2
	);
		return dest != '0 && (dest == a1 || dest == a2);
	endfunction

	// full word results only, a load in EX/MEM still holds its address
	assign exmem_fwd_ok = exmem.valid && exmem.wb.write && !exmem.mem.read &&
		exmem.wb.dest != '0;
	assign memwb_fwd_ok = memwb.valid && memwb.wb.write && memwb.wb.dest != '0;

	assign fwd_exmem_op1 = exmem_fwd_ok && exmem.wb.dest == idex.ex.src1;
	assign fwd_exmem_op2 = exmem_fwd_ok && exmem.wb.dest == idex.ex.src2;
	assign fwd_memwb_op1 = memwb_fwd_ok && memwb.wb.dest == idex.ex.src1;
	assign fwd_memwb_op2 = memwb_fwd_ok && memwb.wb.dest == idex.ex.src2;
	assign fwd_store     = memwb_fwd_ok && memwb.wb.dest == exmem.mem.src;

	// hold the user in decode until the load sits in MEM/WB,
	// so execute never needs a load result from EX/MEM
	assign load_use =
		(idex.valid && idex.mem.read && id_reads(idex.wb.dest, id_raddr1, id_raddr2)) ||
		(exmem.valid && exmem.mem.read && id_reads(exmem.wb.dest, id_raddr1, id_raddr2));

	// flags are written at the end of execute
	assign branch_flags = id_branch_pending && idex.valid && idex.ex.update_flags;

	// half writes are not forwarded, wait for the register file
	assign half_read =
		(idex.valid && (idex.wb.write_lower || idex.wb.write_upper) &&
			id_reads(idex.wb.dest, id_raddr1, id_raddr2)) ||
		(exmem.valid && (exmem.wb.write_lower || exmem.wb.write_upper) &&
			id_reads(exmem.wb.dest, id_raddr1, id_raddr2));

	assign stall = ifid_valid && (load_use || branch_flags || half_read);

endmodule

// File: hdl/cpu_top.sv
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; #(
	parameter int IMEM_ADDR_W = 11,
	parameter int DMEM_ADDR_W = 8
) (
	input  logic                   clk,
	input  logic                   rst_n,
	output logic [IMEM_ADDR_W-1:0] imem_addr,
	input  instr_t                 imem_data,
	output rf_write_t              rf_write
);

	instr_t                 ifid_instr;
	logic [IMEM_ADDR_W-1:0] ifid_pc;
	logic                   ifid_valid;

	logic                   branch;
	logic [IMEM_ADDR_W-1:0] branch_target;
	logic                   link;
	logic [IMEM_ADDR_W-1:0] link_address;
	logic                   ret;

	logic [REG_ADDR_W-1:0]  rf_raddr1;
	logic [REG_ADDR_W-1:0]  rf_raddr2;
	logic [XLEN-1:0]        rf_rdata1;
	logic [XLEN-1:0]        rf_rdata2;

	flags_t                 flags;
	idex_t                  idex;
	exmem_t                 exmem;
	memwb_t                 memwb;
	logic                   id_branch_pending;

	logic                   fwd_exmem_op1;
	logic                   fwd_exmem_op2;
	logic                   fwd_memwb_op1;
	logic                   fwd_memwb_op2;
	logic                   fwd_store;
	logic                   stall;

	fetch_stage #(.IMEM_ADDR_W(IMEM_ADDR_W)) u_fetch_stage (
		.clk           (clk),
		.rst_n         (rst_n),
		.stall         (stall),
		.branch        (branch),
		.branch_target (branch_target),
		.link          (link),
		.link_address  (link_address),
		.ret           (ret),
		.imem_data     (imem_data),
		.imem_addr     (imem_addr),
		.ifid_instr    (ifid_instr),
		.ifid_pc       (ifid_pc),
		.ifid_valid    (ifid_valid)
	);

	decode_stage #(.IMEM_ADDR_W(IMEM_ADDR_W)) u_decode_stage (
		.clk               (clk),
		.rst_n             (rst_n),
		.ifid_instr        (ifid_instr),
		.ifid_pc           (ifid_pc),
		.ifid_valid        (ifid_valid),
		.stall             (stall),
		.flags             (flags),
		.rf_rdata1         (rf_rdata1),
		.rf_rdata2         (rf_rdata2),
		.rf_raddr1         (rf_raddr1),
		.rf_raddr2         (rf_raddr2),
		.branch            (branch),
		.branch_target     (branch_target),
		.link              (link),
		.link_address      (link_address),
		.ret               (ret),
		.idex              (idex),
		.id_branch_pending (id_branch_pending),
		.id_wb             ()
	);

	register_file u_register_file (
		.clk    (clk),
		.rst_n  (rst_n),
		.raddr1 (rf_raddr1),
		.raddr2 (rf_raddr2),
		.rdata1 (rf_rdata1),
		.rdata2 (rf_rdata2),
		.wr     (rf_write)
	);

	execute_stage u_execute_stage (
		.clk           (clk),
		.rst_n         (rst_n),
		.idex          (idex),
		.fwd_exmem_op1 (fwd_exmem_op1),
		.fwd_exmem_op2 (fwd_exmem_op2),
		.fwd_memwb_op1 (fwd_memwb_op1),
		.fwd_memwb_op2 (fwd_memwb_op2),
		.memwb_result  (memwb.result),
		.flags         (flags),
		.exmem         (exmem)
	);

	memory_stage #(.DMEM_ADDR_W(DMEM_ADDR_W)) u_memory_stage (
		.clk          (clk),
		.rst_n        (rst_n),
		.exmem        (exmem),
		.fwd_store    (fwd_store),
		.memwb_result (memwb.result),
		.memwb        (memwb)
	);

	hazard_unit u_hazard_unit (
		.idex              (idex),
		.exmem             (exmem),
		.memwb             (memwb),
		.id_raddr1         (rf_raddr1),
		.id_raddr2         (rf_raddr2),
		.id_branch_pending (id_branch_pending),
		.ifid_valid        (ifid_valid),
		.fwd_exmem_op1     (fwd_exmem_op1),
		.fwd_exmem_op2     (fwd_exmem_op2),
		.fwd_memwb_op1     (fwd_memwb_op1),
		.fwd_memwb_op2     (fwd_memwb_op2),
		.fwd_store         (fwd_store),
		.stall             (stall)
	);

	////////////////////////////////////////
	// write back
	////////////////////////////////////////

	// one pulse per retired full or half register write
	assign rf_write.valid = memwb.valid &&
		(memwb.wb.write || memwb.wb.write_lower || memwb.wb.write_upper);
	assign rf_write.lower = memwb.wb.write_lower;
	assign rf_write.upper = memwb.wb.write_upper;
	assign rf_write.dest  = memwb.wb.dest;
	assign rf_write.data  = memwb.result;

endmodule

// File: tests/tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu import cpu_pkg::*; ();

	localparam int IMEM_ADDR_W  = 11;
	localparam int DMEM_ADDR_W  = 8;
	localparam int CLK_PERIOD   = 20;
	localparam int RESET_CYCLES = 4;
	localparam int DRIVE_DELAY  = 1;
	localparam int STIM_DEPTH   = 128;
	// the self loop at the end must stay silent
	localparam int QUIET_CYCLES = 20;

	logic                   clk;
	logic                   rst_n;
	logic [IMEM_ADDR_W-1:0] imem_addr;
	instr_t                 imem_data;
	rf_write_t              rf_write;

	logic [31:0]            stim [STIM_DEPTH];
	logic [IMEM_ADDR_W-1:0] fetch_addr;
	int                     prog_len;
	int                     exp_count;
	int                     writes_seen;
	int                     cycles;
	int                     cycle_limit;

	cpu_top #(
		.IMEM_ADDR_W (IMEM_ADDR_W),
		.DMEM_ADDR_W (DMEM_ADDR_W)
	) u_cpu_top (
		.clk       (clk),
		.rst_n     (rst_n),
		.imem_addr (imem_addr),
		.imem_data (imem_data),
		.rf_write  (rf_write)
	);

	always #(CLK_PERIOD/2) clk = ~clk;

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////

	// words past the program read as empty
	function automatic logic [31:0] program_word(input logic [IMEM_ADDR_W-1:0] addr);
		if (int'(addr) < prog_len) begin
			return stim[1 + int'(addr)];
		end
		return '0;
	endfunction

	// same layout as the tag column of the stimulus file
	function automatic logic [31:0] write_tag(input rf_write_t w);
		return {19'd0, w.upper, 3'd0, w.lower, 3'd0, w.dest};
	endfunction

	task automatic stop_with_error(input string reason);
		$display("%s", reason);
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(
		input logic [31:0] actual,
		input logic [31:0] expected,
		input string       what
	);
		if (actual !== expected) begin
			stop_with_error($sformatf("CHECK FAILED at %0t ns: %s expected %h, got %h",
				$time, what, expected, actual));
		end
	endtask

	////////////////////////////////////////
	// instruction memory and monitors
	////////////////////////////////////////

	// address is settled mid-cycle, latched as a block RAM would at the next edge
	always @(negedge clk) begin
		fetch_addr = imem_addr;
	end

	always @(posedge clk) begin
		#DRIVE_DELAY;
		imem_data = program_word(fetch_addr);
	end

	// one pulse per retired write, compared in order
	always @(negedge clk) begin
		if (rst_n && rf_write.valid) begin
			if (writes_seen >= exp_count) begin
				stop_with_error($sformatf("unexpected write to r%0d after the last expected write",
					rf_write.dest));
			end else begin
				check_value(write_tag(rf_write), stim[prog_len + 2 + 2 * writes_seen],
					$sformatf("write %0d target", writes_seen));
				check_value(rf_write.data, stim[prog_len + 3 + 2 * writes_seen],
					$sformatf("write %0d data", writes_seen));
				writes_seen++;
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			stop_with_error($sformatf("timeout: the program did not finish in %0d cycles", cycles));
		end
	end

	initial begin
		clk         = 1'b0;
		rst_n       = 1'b0;
		imem_data   = '0;
		fetch_addr  = '0;
		writes_seen = 0;
		cycles      = 0;
		cycle_limit = 0;
		$readmemh("tests/cpu_stimulus.txt", stim);
		prog_len = int'(stim[0]);
		if (prog_len <= 0 || prog_len + 2 > STIM_DEPTH) begin
			stop_with_error("stimulus file is missing or its program length is wrong");
		end
		exp_count = int'(stim[prog_len + 1]);
		if (exp_count <= 0 || prog_len + 2 + 2 * exp_count > STIM_DEPTH) begin
			stop_with_error("stimulus file has a wrong count of expected writes");
		end
		cycle_limit = 20 * prog_len + 100;

		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		rst_n = 1'b1;

		wait (writes_seen == exp_count);
		repeat (QUIET_CYCLES) @(posedge clk);
		$display("%0d register writes matched", exp_count);
		$display("NO ERRORS");
		$finish;
	end

endmodule

// File: project.f
hdl/cpu_pkg.sv
hdl/register_file.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/hazard_unit.sv
hdl/cpu_top.sv
tests/tb_cpu.sv

// File: tests/cpu_stimulus.txt
// word 0: program length, then the program words, then the number of expected writes
// expected writes are tag/data pairs, tag = dest in bits 4:0, lower in bit 8, upper in bit 12
23
// alu chain with forwarding, words 0 to 11
0840000C 0882FFFB 00C22000 11043000 19483000 298A2000
39CC4000 420C2000 4A482000 52882000 22CE00FF 33160100
// lli and lui to r13, add of the merged register, words 12 to 14
5B409ABC 63401234 039A0000
// sw, lw with a use right after, swo, lwo, words 15 to 19
73800020 6BC00020 0C1E0001 84020034 7C440039
// write to r0, then add from r0, words 20 and 21
08060064 0480C000
// flag setters and branches, the 0BAD words are skipped, words 22 to 29
14C21000 89000001 0D000BAD 15441000 8C000001 0D800033 8A000001 0DC00BAD
// bl, caller tail, self loop, subroutine body, ret, words 30 to 34
97000002 0E400044 8F00FFFF 0E800055 98000000
// expected writes in retire order
19
001 0000000C   002 00000007
003 00000013   004 FFFFFFF4
005 00000010   006 00000017
007 FFFFFFE3   008 00000B80
009 01FFFFFF   00A FFFFFFFF
00B 000000E3   00C 000001E3
// lower then upper half of r13
10D FFFF9ABC   100D 00001234
00E 12349ABC   00F 12349ABC
010 12349ABD   011 12349ABD
// r0 shows on the port but stays zero
000 00000077   012 000001E3
013 00000000   015 FFFFFFFB
// subroutine first, then the caller
016 00000033   01A 00000055
019 00000044
